/* Makefile */
TOOL   := verilator
FLAGS  := --binary --timing --assert
TOP    := tb_md_cluster
FLIST  := list.f
OBJDIR := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR)

/* list.f */
rtl/md_pkg.sv
rtl/md_lane.sv
rtl/md_axi_dispatch.sv
rtl/md_axi_readback.sv
rtl/md_cluster_top.sv
tests/tb_md_cluster.sv

/* rtl/md_axi_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module md_axi_dispatch (
    input  wire                                                clk,
    input  wire                                                reset,
    input  wire                                                awvalid,
    output logic                                               awready,
    input  wire [md_pkg::addr_width-1:0]                       awaddr,
    input  wire                                                wvalid,
    output logic                                               wready,
    input  wire [md_pkg::data_width-1:0]                       wdata,
    input  wire [md_pkg::data_width/8-1:0]                     wstrb,
    output logic                                               bvalid,
    input  wire                                                bready,
    output logic [1:0]                                         bresp,
    input  wire [md_pkg::lane_count-1:0]                       lane_busy,
    output logic [md_pkg::lane_count-1:0]                      lane_start,
    output logic [3:0]                                         issue_op,
    output logic [md_pkg::lane_count-1:0][md_pkg::data_width-1:0] lane_a,
    output logic [md_pkg::lane_count-1:0][md_pkg::data_width-1:0] lane_b
);

    localparam int lane_lsb = md_pkg::off_width;
    localparam int page_lsb = md_pkg::off_width + md_pkg::lane_idx_width;

    logic                              accept;
    logic [md_pkg::lane_idx_width-1:0] wr_lane;
    logic [md_pkg::off_width-1:0]      wr_off;
    logic                              wr_mapped;
    logic                              op_legal;
    logic                              op_ok;
    logic                              wr_err;
    logic                              do_start;

    // address and data are taken together on one edge.
    assign accept  = awvalid && wvalid && !bvalid;
    assign awready = accept;
    assign wready  = accept;

    assign wr_lane   = awaddr[lane_lsb +: md_pkg::lane_idx_width];
    assign wr_off    = awaddr[md_pkg::off_width-1:0];
    assign wr_mapped = (awaddr >> page_lsb) == '0;

    assign op_legal = (wdata[7:4] == 4'd0) &&
                      (wdata[3:0] inside {md_pkg::op_mthi, md_pkg::op_mtlo,
                                          md_pkg::op_mult, md_pkg::op_multu,
                                          md_pkg::op_div,  md_pkg::op_divu});
    assign op_ok    = op_legal && wstrb[0] && !lane_busy[wr_lane];

    always_comb begin
        case (wr_off)
            md_pkg::reg_a, md_pkg::reg_b: wr_err = 1'b0;
            md_pkg::reg_op:               wr_err = !op_ok;
            default:                      wr_err = 1'b1;   // hi, lo, status, holes.
        endcase
        if (!wr_mapped) begin
            wr_err = 1'b1;
        end
    end

    assign do_start = accept && wr_mapped && (wr_off == md_pkg::reg_op) && op_ok;

    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid     <= 1'b0;
            bresp      <= md_pkg::resp_okay;
            lane_start <= '0;
        end else begin
            lane_start <= '0;
            if (accept) begin
                bvalid <= 1'b1;
                bresp  <= wr_err ? md_pkg::resp_slverr : md_pkg::resp_okay;
                if (do_start) begin
                    lane_start[wr_lane] <= 1'b1;   // one-cycle pulse.
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // operand storage with per-byte strobes.
    always_ff @(posedge clk) begin
        if (accept && wr_mapped) begin
            for (int i = 0; i < md_pkg::data_width / 8; i++) begin
                if (wstrb[i]) begin
                    if (wr_off == md_pkg::reg_a) begin
                        lane_a[wr_lane][8*i +: 8] <= wdata[8*i +: 8];
                    end
                    if (wr_off == md_pkg::reg_b) begin
                        lane_b[wr_lane][8*i +: 8] <= wdata[8*i +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_start) begin
            issue_op <= wdata[3:0];   // shared by all lanes.
        end
    end

endmodule

`default_nettype wire

/* rtl/md_axi_readback.sv */
`timescale 1ns/1ps
`default_nettype none

module md_axi_readback (
    input  wire                                                clk,
    input  wire                                                reset,
    input  wire                                                arvalid,
    output logic                                               arready,
    input  wire [md_pkg::addr_width-1:0]                       araddr,
    output logic                                               rvalid,
    input  wire                                                rready,
    output logic [md_pkg::data_width-1:0]                      rdata,
    output logic [1:0]                                         rresp,
    input  wire [md_pkg::lane_count-1:0]                       lane_busy,
    input  wire [md_pkg::lane_count-1:0][md_pkg::data_width-1:0] lane_hi,
    input  wire [md_pkg::lane_count-1:0][md_pkg::data_width-1:0] lane_lo
);

    localparam int lane_lsb = md_pkg::off_width;
    localparam int page_lsb = md_pkg::off_width + md_pkg::lane_idx_width;

    logic                              rd_accept;
    logic [md_pkg::lane_idx_width-1:0] rd_lane;
    logic [md_pkg::off_width-1:0]      rd_off;
    logic                              rd_mapped;
    logic [md_pkg::data_width-1:0]     rd_data;
    logic [1:0]                        rd_resp;

    assign rd_accept = arvalid && arready;

    assign rd_lane   = araddr[lane_lsb +: md_pkg::lane_idx_width];
    assign rd_off    = araddr[md_pkg::off_width-1:0];
    assign rd_mapped = (araddr >> page_lsb) == '0;

    always_comb begin
        rd_data = '0;
        rd_resp = md_pkg::resp_okay;
        case (rd_off)
            md_pkg::reg_hi:     rd_data = lane_hi[rd_lane];
            md_pkg::reg_lo:     rd_data = lane_lo[rd_lane];
            md_pkg::reg_status: rd_data = {{(md_pkg::data_width-1){1'b0}}, lane_busy[rd_lane]};
            default:            rd_resp = md_pkg::resp_slverr;   // operands are write only.
        endcase
        if (!rd_mapped) begin
            rd_data = '0;
            rd_resp = md_pkg::resp_slverr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else if (rd_accept) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;
        end else if (rvalid && rready) begin
            arready <= 1'b1;
            rvalid  <= 1'b0;
        end else if (!rvalid) begin
            arready <= 1'b1;   // first cycle out of reset.
        end
    end

    // held stable while rvalid waits for rready.
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata <= rd_data;
            rresp <= rd_resp;
        end
    end

endmodule

`default_nettype wire

/* rtl/md_cluster_top.sv */
`timescale 1ns/1ps
`default_nettype none

module md_cluster_top (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               awvalid,
    output logic                              awready,
    input  wire [md_pkg::addr_width-1:0]      awaddr,
    input  wire                               wvalid,
    output logic                              wready,
    input  wire [md_pkg::data_width-1:0]      wdata,
    input  wire [md_pkg::data_width/8-1:0]    wstrb,
    output logic                              bvalid,
    input  wire                               bready,
    output logic [1:0]                        bresp,
    input  wire                               arvalid,
    output logic                              arready,
    input  wire [md_pkg::addr_width-1:0]      araddr,
    output logic                              rvalid,
    input  wire                               rready,
    output logic [md_pkg::data_width-1:0]     rdata,
    output logic [1:0]                        rresp
);

    logic [md_pkg::lane_count-1:0]                          lane_start;
    logic [md_pkg::lane_count-1:0]                          lane_busy;
    logic [3:0]                                             issue_op;
    logic [md_pkg::lane_count-1:0][md_pkg::data_width-1:0]  lane_a;
    logic [md_pkg::lane_count-1:0][md_pkg::data_width-1:0]  lane_b;
    logic [md_pkg::lane_count-1:0][md_pkg::data_width-1:0]  lane_hi;
    logic [md_pkg::lane_count-1:0][md_pkg::data_width-1:0]  lane_lo;

    md_axi_dispatch u_dispatch (
        .clk        (clk),
        .reset      (reset),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .lane_busy  (lane_busy),
        .lane_start (lane_start),
        .issue_op   (issue_op),
        .lane_a     (lane_a),
        .lane_b     (lane_b)
    );

    for (genvar i = 0; i < md_pkg::lane_count; i++) begin : g_lane
        md_lane u_lane (
            .clk   (clk),
            .reset (reset),
            .start (lane_start[i]),
            .op    (issue_op),
            .a     (lane_a[i]),
            .b     (lane_b[i]),
            .busy  (lane_busy[i]),
            .hi    (lane_hi[i]),
            .lo    (lane_lo[i])
        );
    end

    md_axi_readback u_readback (
        .clk       (clk),
        .reset     (reset),
        .arvalid   (arvalid),
        .arready   (arready),
        .araddr    (araddr),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .lane_busy (lane_busy),
        .lane_hi   (lane_hi),
        .lane_lo   (lane_lo)
    );

endmodule

`default_nettype wire

/* rtl/md_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module md_lane (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              start,
    input  wire [3:0]                        op,
    input  wire [md_pkg::data_width-1:0]     a,
    input  wire [md_pkg::data_width-1:0]     b,
    output logic                             busy,
    output logic [md_pkg::data_width-1:0]    hi,
    output logic [md_pkg::data_width-1:0]    lo
);

    localparam int dw = md_pkg::data_width;

    md_pkg::md_result_u res_d;
    md_pkg::md_result_u res_q;

    logic [md_pkg::count_width-1:0] cnt;
    logic                           div_zero;
    logic                           div_ovf;

    assign div_zero = (b == '0);
    assign div_ovf  = (a == {1'b1, {(dw-1){1'b0}}}) && (b == '1);   // most negative / -1.

    always_comb begin
        res_d = '0;
        case (op)
            md_pkg::op_mult: begin
                res_d.product = {{dw{a[dw-1]}}, a} * {{dw{b[dw-1]}}, b};
            end
            md_pkg::op_multu: begin
                res_d.product = {{dw{1'b0}}, a} * {{dw{1'b0}}, b};
            end
            md_pkg::op_div: begin
                if (div_zero) begin
                    res_d.divres[md_pkg::half_lo] = '1;
                    res_d.divres[md_pkg::half_hi] = a;
                end else if (div_ovf) begin
                    res_d.divres[md_pkg::half_lo] = a;
                    res_d.divres[md_pkg::half_hi] = '0;
                end else begin
                    res_d.divres[md_pkg::half_lo] = dw'($signed(a) / $signed(b));
                    res_d.divres[md_pkg::half_hi] = dw'($signed(a) % $signed(b));
                end
            end
            md_pkg::op_divu: begin
                if (div_zero) begin
                    res_d.divres[md_pkg::half_lo] = '1;
                    res_d.divres[md_pkg::half_hi] = a;
                end else begin
                    res_d.divres[md_pkg::half_lo] = a / b;
                    res_d.divres[md_pkg::half_hi] = a % b;
                end
            end
            default: begin
                res_d = '0;   // moves go straight to hi/lo.
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (start) begin
            res_q <= res_d;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
            hi  <= '0;
            lo  <= '0;
        end else if (start) begin
            case (op)
                md_pkg::op_mthi: begin
                    hi <= a;
                end
                md_pkg::op_mtlo: begin
                    lo <= a;
                end
                md_pkg::op_mult, md_pkg::op_multu: begin
                    cnt <= md_pkg::count_width'(md_pkg::mult_latency);
                end
                md_pkg::op_div, md_pkg::op_divu: begin
                    cnt <= md_pkg::count_width'(md_pkg::div_latency);
                end
                default: begin
                    cnt <= cnt;
                end
            endcase
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
            if (cnt == 1) begin   // last cycle of the countdown.
                hi <= res_q.divres[md_pkg::half_hi];
                lo <= res_q.divres[md_pkg::half_lo];
            end
        end
    end

    assign busy = (cnt != '0);

endmodule

`default_nettype wire

/* rtl/md_pkg.sv */
`default_nettype none

package md_pkg;

    localparam int lane_count     = 4;
    localparam int lane_idx_width = $clog2(lane_count);

    localparam int addr_width  = 8;
    localparam int data_width  = 32;
    localparam int lane_stride = 32;
    localparam int off_width   = $clog2(lane_stride);   // offset bits within a lane window.

    // register offsets inside one lane window.
    localparam logic [off_width-1:0] reg_a      = 5'h00;
    localparam logic [off_width-1:0] reg_b      = 5'h04;
    localparam logic [off_width-1:0] reg_op     = 5'h08;   // write starts the lane.
    localparam logic [off_width-1:0] reg_hi     = 5'h0C;
    localparam logic [off_width-1:0] reg_lo     = 5'h10;
    localparam logic [off_width-1:0] reg_status = 5'h14;   // bit 0 is busy.

    localparam logic [3:0] op_mthi  = 4'd1;
    localparam logic [3:0] op_mtlo  = 4'd2;
    localparam logic [3:0] op_mult  = 4'd3;
    localparam logic [3:0] op_multu = 4'd4;
    localparam logic [3:0] op_div   = 4'd5;
    localparam logic [3:0] op_divu  = 4'd6;

    localparam int mult_latency = 5;
    localparam int div_latency  = 10;
    localparam int count_width  = $clog2(div_latency + 1);

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // halves of the result word, hi half is also the remainder.
    localparam int half_hi = 1;
    localparam int half_lo = 0;

    // one 64-bit result, seen as a product or as remainder/quotient.
    typedef union packed {
        logic [2*data_width-1:0]          product;
        logic [1:0][data_width-1:0]       divres;
    } md_result_u;

endpackage

`default_nettype wire

/* tests/tb_md_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_md_cluster;

    localparam int timeout_cycles = 100;
    localparam int max_polls      = 40;
    localparam int random_rows    = 8;

    logic                              clk;
    logic                              reset;
    logic                              awvalid;
    wire                               awready;
    logic [md_pkg::addr_width-1:0]     awaddr;
    logic                              wvalid;
    wire                               wready;
    logic [md_pkg::data_width-1:0]     wdata;
    logic [md_pkg::data_width/8-1:0]   wstrb;
    wire                               bvalid;
    logic                              bready;
    wire  [1:0]                        bresp;
    logic                              arvalid;
    wire                               arready;
    logic [md_pkg::addr_width-1:0]     araddr;
    wire                               rvalid;
    logic                              rready;
    wire  [md_pkg::data_width-1:0]     rdata;
    wire  [1:0]                        rresp;

    integer seed;
    int     errors;
    int     checks;
    int     timeouts;

    logic [31:0] exp_hi   [md_pkg::lane_count];
    logic [31:0] exp_lo   [md_pkg::lane_count];
    logic [31:0] shadow_a [md_pkg::lane_count];   // operands as the lanes should hold them.
    logic [31:0] shadow_b [md_pkg::lane_count];

    int          row_lane [$];
    logic [3:0]  row_op   [$];
    logic [31:0] row_a    [$];
    logic [31:0] row_b    [$];

    md_cluster_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic finish_run();
        $display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout at %0t: the %s never completed", $time, what);
    endtask

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [md_pkg::addr_width-1:0] reg_addr(input int lane,
                                                                input logic [4:0] off);
        return md_pkg::addr_width'(lane * md_pkg::lane_stride + int'(off));
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nv,
                                                input logic [3:0] strb);
        logic [31:0] m;
        m = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                m[8*i +: 8] = nv[8*i +: 8];
            end
        end
        return m;
    endfunction

    // reference result, built from the arithmetic rules and the two defined divide cases.
    function automatic md_pkg::md_result_u model_result(input logic [3:0] op,
                                                        input logic [31:0] a,
                                                        input logic [31:0] b);
        md_pkg::md_result_u r;
        int                 sa;
        int                 sb;
        sa = a;
        sb = b;
        r  = '0;
        if (op == md_pkg::op_mult) begin
            r.product = longint'(sa) * longint'(sb);
        end else if (op == md_pkg::op_multu) begin
            r.product = {32'd0, a} * {32'd0, b};
        end else if (b == 32'd0) begin   // divide by zero, either sign.
            r.divres[md_pkg::half_hi] = a;
            r.divres[md_pkg::half_lo] = 32'hffff_ffff;
        end else if (op == md_pkg::op_div && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            r.divres[md_pkg::half_hi] = 32'd0;
            r.divres[md_pkg::half_lo] = a;
        end else if (op == md_pkg::op_div) begin
            r.divres[md_pkg::half_hi] = sa % sb;
            r.divres[md_pkg::half_lo] = sa / sb;
        end else begin
            r.divres[md_pkg::half_hi] = a % b;
            r.divres[md_pkg::half_lo] = a / b;
        end
        return r;
    endfunction

    task automatic update_model(input int lane, input logic [3:0] op);
        md_pkg::md_result_u r;
        if (op == md_pkg::op_mthi) begin
            exp_hi[lane] = shadow_a[lane];
        end else if (op == md_pkg::op_mtlo) begin
            exp_lo[lane] = shadow_a[lane];
        end else begin
            r = model_result(op, shadow_a[lane], shadow_b[lane]);
            exp_hi[lane] = r.divres[md_pkg::half_hi];
            exp_lo[lane] = r.divres[md_pkg::half_lo];
        end
    endtask

    // called and returns on a falling edge.
    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        int count;
        int delay;
        count   = 0;
        delay   = $unsigned($random(seed)) % 4;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(posedge clk);   // ready follows valid within the cycle.
        while (!(awready && wready) && count < timeout_cycles) begin
            @(posedge clk);
            count++;
        end
        if (count >= timeout_cycles) begin
            report_timeout("write address and data handshake");
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat (delay) @(negedge clk);   // bready back-pressure.
        bready = 1'b1;
        count  = 0;
        while (!bvalid && count < timeout_cycles) begin
            @(negedge clk);
            count++;
        end
        if (count >= timeout_cycles) begin
            report_timeout("write response handshake");
        end
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
        check_value("bvalid after its handshake", 32'(bvalid), 32'd0);
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int count;
        int delay;
        count   = 0;
        delay   = $unsigned($random(seed)) % 4;
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready && count < timeout_cycles) begin
            @(negedge clk);
            count++;
        end
        if (count >= timeout_cycles) begin
            report_timeout("read address handshake");
        end
        @(negedge clk);
        arvalid = 1'b0;
        repeat (delay) @(negedge clk);   // rready back-pressure.
        rready = 1'b1;
        count  = 0;
        while (!rvalid && count < timeout_cycles) begin
            @(negedge clk);
            count++;
        end
        if (count >= timeout_cycles) begin
            report_timeout("read data handshake");
        end
        data = rdata;
        resp = rresp;
        @(negedge clk);
        rready = 1'b0;
        check_value("rvalid after its handshake", 32'(rvalid), 32'd0);
    endtask

    task automatic write_operand(input int lane, input logic [4:0] off, input logic [31:0] data,
                                 input logic [3:0] strb);
        logic [1:0] resp;
        axi_write(reg_addr(lane, off), data, strb, resp);
        check_value($sformatf("lane %0d operand write resp", lane), 32'(resp), 32'd0);
        if (off == md_pkg::reg_a) begin
            shadow_a[lane] = merge_bytes(shadow_a[lane], data, strb);
        end else begin
            shadow_b[lane] = merge_bytes(shadow_b[lane], data, strb);
        end
    endtask

    task automatic start_lane(input int lane, input logic [3:0] op, input logic [1:0] exp_resp);
        logic [1:0] resp;
        axi_write(reg_addr(lane, md_pkg::reg_op), {28'd0, op}, 4'hf, resp);
        check_value($sformatf("lane %0d opcode %0d resp", lane, op), 32'(resp), 32'(exp_resp));
        if (exp_resp == md_pkg::resp_okay) begin
            update_model(lane, op);
        end
    endtask

    task automatic wait_idle(input int lane);
        logic [31:0] data;
        logic [1:0]  resp;
        int          polls;
        polls = 0;
        data  = 32'd1;
        while (data[0] && polls < max_polls) begin
            axi_read(reg_addr(lane, md_pkg::reg_status), data, resp);
            polls++;
        end
        if (data[0]) begin
            report_timeout($sformatf("busy clear on lane %0d", lane));
        end
    endtask

    task automatic check_lane(input int lane);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(reg_addr(lane, md_pkg::reg_hi), data, resp);
        check_value($sformatf("lane %0d hi resp", lane), 32'(resp), 32'd0);
        check_value($sformatf("lane %0d hi", lane), data, exp_hi[lane]);
        axi_read(reg_addr(lane, md_pkg::reg_lo), data, resp);
        check_value($sformatf("lane %0d lo resp", lane), 32'(resp), 32'd0);
        check_value($sformatf("lane %0d lo", lane), data, exp_lo[lane]);
    endtask

    task automatic run_row(input int lane, input logic [3:0] op, input logic [31:0] a,
                           input logic [31:0] b);
        logic [31:0] data;
        logic [1:0]  resp;
        write_operand(lane, md_pkg::reg_a, a, 4'hf);
        write_operand(lane, md_pkg::reg_b, b, 4'hf);
        start_lane(lane, op, md_pkg::resp_okay);
        if (op == md_pkg::op_mthi || op == md_pkg::op_mtlo) begin
            axi_read(reg_addr(lane, md_pkg::reg_status), data, resp);
            check_value($sformatf("lane %0d status after move", lane), data, 32'd0);
        end
        wait_idle(lane);
        check_lane(lane);
    endtask

    task automatic add_row(input int lane, input logic [3:0] op, input logic [31:0] a,
                           input logic [31:0] b);
        row_lane.push_back(lane);
        row_op.push_back(op);
        row_a.push_back(a);
        row_b.push_back(b);
    endtask

    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        seed     = 32'h9d913714;
        errors   = 0;
        checks   = 0;
        timeouts = 0;
        reset    = 1'b1;
        awvalid  = 1'b0;
        awaddr   = '0;
        wvalid   = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        bready   = 1'b0;
        arvalid  = 1'b0;
        araddr   = '0;
        rready   = 1'b0;
        for (int i = 0; i < md_pkg::lane_count; i++) begin
            exp_hi[i]   = '0;
            exp_lo[i]   = '0;
            shadow_a[i] = '0;
            shadow_b[i] = '0;
        end
        repeat (10) @(negedge clk);
        check_value("bus handshakes in reset",
                    32'({awready, wready, bvalid, arready, rvalid}), 32'd0);
        reset = 1'b0;
        for (int i = 0; i < md_pkg::lane_count; i++) begin
            check_lane(i);
        end

        add_row(0, md_pkg::op_mult,  32'd7,         32'hffff_fffd);
        add_row(1, md_pkg::op_multu, 32'hffff_ffff, 32'hffff_ffff);
        add_row(2, md_pkg::op_mult,  32'h8000_0000, 32'h8000_0000);
        add_row(3, md_pkg::op_mult,  32'hffff_fff0, 32'h1234_5678);
        add_row(0, md_pkg::op_div,   32'hffff_ff9c, 32'd7);           // -100 / 7.
        add_row(1, md_pkg::op_divu,  32'hffff_ff9c, 32'd7);
        add_row(2, md_pkg::op_div,   32'd7,         32'hffff_fffe);
        add_row(3, md_pkg::op_div,   32'h8000_0000, 32'hffff_ffff);   // overflow case.
        add_row(0, md_pkg::op_div,   32'hdead_beef, 32'd0);
        add_row(1, md_pkg::op_divu,  32'd5,         32'd0);
        add_row(2, md_pkg::op_mthi,  32'h0bad_f00d, 32'd0);
        add_row(2, md_pkg::op_mtlo,  32'hcafe_0001, 32'd0);
        add_row(3, md_pkg::op_mtlo,  32'h1357_9bdf, 32'd0);
        for (int i = 0; i < random_rows; i++) begin
            add_row($unsigned($random(seed)) % 4, 4'(3 + $unsigned($random(seed)) % 4),
                    $random(seed), $random(seed));
        end
        for (int i = 0; i < row_lane.size(); i++) begin
            run_row(row_lane[i], row_op[i], row_a[i], row_b[i]);
        end

        // opcode to a busy lane is refused and the pending divide survives.
        write_operand(0, md_pkg::reg_a, 32'd1000, 4'hf);
        write_operand(0, md_pkg::reg_b, 32'd9, 4'hf);
        start_lane(0, md_pkg::op_divu, md_pkg::resp_okay);
        start_lane(0, md_pkg::op_mult, md_pkg::resp_slverr);
        wait_idle(0);
        check_lane(0);

        start_lane(1, 4'd0, md_pkg::resp_slverr);
        start_lane(1, 4'd7, md_pkg::resp_slverr);
        start_lane(1, 4'hf, md_pkg::resp_slverr);
        axi_write(reg_addr(1, md_pkg::reg_op), 32'(md_pkg::op_mult), 4'b1110, resp);
        check_value("opcode write without byte 0 resp", 32'(resp), 32'(md_pkg::resp_slverr));
        axi_write(reg_addr(1, md_pkg::reg_hi), 32'h5555_aaaa, 4'hf, resp);
        check_value("hi write resp", 32'(resp), 32'(md_pkg::resp_slverr));
        wait_idle(1);
        check_lane(1);
        axi_read(reg_addr(2, 5'h18), data, resp);
        check_value("unmapped read resp", 32'(resp), 32'(md_pkg::resp_slverr));
        check_value("unmapped read data", data, 32'd0);
        axi_read(reg_addr(2, md_pkg::reg_a), data, resp);
        check_value("operand read resp", 32'(resp), 32'(md_pkg::resp_slverr));
        axi_read(8'h80, data, resp);
        check_value("read past the lanes resp", 32'(resp), 32'(md_pkg::resp_slverr));

        // all four divides in flight before any polling.
        for (int i = 0; i < md_pkg::lane_count; i++) begin
            write_operand(i, md_pkg::reg_a, $random(seed), 4'hf);
            write_operand(i, md_pkg::reg_b, 32'(1 + $unsigned($random(seed)) % 1000), 4'hf);
        end
        for (int i = 0; i < md_pkg::lane_count; i++) begin
            start_lane(i, (i % 2 == 0) ? md_pkg::op_div : md_pkg::op_divu, md_pkg::resp_okay);
        end
        for (int i = 0; i < md_pkg::lane_count; i++) begin
            wait_idle(i);
            check_lane(i);
        end

        write_operand(1, md_pkg::reg_a, 32'h1122_3344, 4'hf);
        write_operand(1, md_pkg::reg_a, 32'haabb_ccdd, 4'b0101);   // bytes 0 and 2 only.
        write_operand(1, md_pkg::reg_b, 32'd3, 4'hf);
        start_lane(1, md_pkg::op_multu, md_pkg::resp_okay);
        wait_idle(1);
        check_lane(1);

        finish_run();
    end

endmodule

`default_nettype wire
